// ==== common/mm_bus_pkg.sv ====
/*
 * Bus definitions shared by the core ports, the decoder and the RAM.
 */
`default_nettype none

package mm_bus_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [BE_W-1:0]   be_t;

    // source of the registered read data
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_ROM,
        SEL_UNMAP,
        SEL_IDLE
    } read_sel_e;

endpackage

`default_nettype wire

// ==== common/mm_map_pkg.sv ====
/*
 * Memory map of the simulation memory system. Holds the region bases and
 * lengths, the special data words and the region classification.
 */
`default_nettype none

package mm_map_pkg;

    // sram is also mirrored at address zero
    localparam logic [31:0] SRAM_BASE = 32'h1C00_0000;

    localparam logic [31:0] ROM_BASE = 32'h1A00_0000;
    localparam logic [31:0] ROM_LEN  = 32'h0000_1000;

    localparam logic [31:0] CNTRL_BASE = 32'h1A10_4000;
    localparam logic [31:0] CNTRL_LEN  = 32'h0000_1000;

    localparam logic [31:0] TIMER_BASE = 32'h1A10_B000;
    localparam logic [31:0] TIMER_LEN  = 32'h0000_1000;

    // register offsets inside the timer region
    localparam logic [31:0] TIMER_MASK_OFS = 32'h0000_0000;
    localparam logic [31:0] TIMER_CNT_OFS  = 32'h0000_0004;

    localparam logic [31:0] PASS_CODE = 32'h0000_F00D;

    // jal x0, 0
    localparam logic [31:0] BOOT_LOOP_INSTR = 32'h0000_006F;

    // mask bit and interrupt id of the timer
    localparam logic [4:0] TIMER_IRQ_ID = 5'd3;

    typedef enum logic [2:0] {
        REG_RAM,
        REG_ROM,
        REG_CNTRL,
        REG_TIMER,
        REG_UNMAP
    } region_e;

endpackage

`default_nettype wire

// ==== common/mem_port_if.sv ====
/*
 * Word-wide memory request port. The controller issues requests, the
 * memory accepts every request and returns read data one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
);
    import mm_bus_pkg::*;

    logic                      req;
    // byte address, low two bits ignored by the memory
    logic [RAM_ADDR_WIDTH-1:0] addr;
    logic                      we;
    be_t                       be;
    word_t                     wdata;
    word_t                     rdata;

    modport ctrl (
        output req, addr, we, be, wdata,
        input  rdata
    );

    modport mem (
        input  req, addr, we, be, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== design/mm_decoder.sv ====
/*
 * Address decoder for the fetch and core data ports. Steers each access to
 * RAM, boot ROM, test control or timer, generates grant and rvalid and
 * muxes the read data one cycle after the grant.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_decoder #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,

    input  wire logic                      instr_req_i,
    input  wire mm_bus_pkg::addr_t         instr_addr_i,
    output logic                           instr_gnt_o,
    output logic                           instr_rvalid_o,
    output mm_bus_pkg::word_t              instr_rdata_o,

    input  wire logic                      data_req_i,
    input  wire mm_bus_pkg::addr_t         data_addr_i,
    input  wire logic                      data_we_i,
    input  wire mm_bus_pkg::be_t           data_be_i,
    input  wire mm_bus_pkg::word_t         data_wdata_i,
    output logic                           data_gnt_o,
    output logic                           data_rvalid_o,
    output mm_bus_pkg::word_t              data_rdata_o,

    output logic                           tests_passed_o,
    output logic                           tests_failed_o,

    mem_port_if.ctrl                       ram_port,

    output logic                           fetch_req_o,
    output logic [RAM_ADDR_WIDTH-1:0]      fetch_addr_o,
    input  wire mm_bus_pkg::word_t         fetch_rdata_i,

    output logic                           timer_we_o,
    output logic                           timer_sel_cnt_o,
    output mm_bus_pkg::word_t              timer_wdata_o
);
    import mm_bus_pkg::*;
    import mm_map_pkg::*;

    localparam addr_t SRAM_LEN = addr_t'(2 ** RAM_ADDR_WIDTH);

    region_e   instr_region;
    region_e   data_region;
    logic      data_rd;
    logic      data_wr;
    addr_t     timer_ofs;
    read_sel_e instr_sel_d, instr_sel_q;
    read_sel_e data_sel_d, data_sel_q;
    logic      instr_rvalid_q;
    logic      data_rvalid_q;

    function automatic region_e classify(addr_t a);
        // ram mirrored at zero and at the sram base
        if ((a >= SRAM_BASE && a < SRAM_BASE + SRAM_LEN) || a < SRAM_LEN) begin
            return REG_RAM;
        end else if (a >= ROM_BASE && a < ROM_BASE + ROM_LEN) begin
            return REG_ROM;
        end else if (a >= CNTRL_BASE && a < CNTRL_BASE + CNTRL_LEN) begin
            return REG_CNTRL;
        end else if (a >= TIMER_BASE && a < TIMER_BASE + TIMER_LEN) begin
            return REG_TIMER;
        end
        return REG_UNMAP;
    endfunction

    // only ram and rom return data, everything else reads as zero
    function automatic read_sel_e sel_for(region_e r);
        case (r)
            REG_RAM: return SEL_RAM;
            REG_ROM: return SEL_ROM;
            default: return SEL_UNMAP;
        endcase
    endfunction

    function automatic word_t read_mux(read_sel_e s, word_t ram_rdata);
        case (s)
            SEL_RAM: return ram_rdata;
            SEL_ROM: return BOOT_LOOP_INSTR;
            default: return '0;
        endcase
    endfunction

    assign instr_region = classify(instr_addr_i);
    assign data_region  = classify(data_addr_i);
    assign data_rd      = data_req_i && !data_we_i;
    assign data_wr      = data_req_i && data_we_i;

    assign data_gnt_o  = data_req_i;
    // ram fetches use their own port, other fetches wait for an idle data port
    assign instr_gnt_o = instr_req_i && (instr_region == REG_RAM || !data_req_i);

    assign ram_port.req   = data_req_i && data_region == REG_RAM;
    assign ram_port.addr  = data_addr_i[RAM_ADDR_WIDTH-1:0];
    assign ram_port.we    = data_we_i;
    assign ram_port.be    = data_be_i;
    assign ram_port.wdata = data_wdata_i;

    assign fetch_req_o  = instr_req_i && instr_region == REG_RAM;
    assign fetch_addr_o = instr_addr_i[RAM_ADDR_WIDTH-1:0];

    assign tests_passed_o = data_wr && data_region == REG_CNTRL && data_wdata_i == PASS_CODE;
    assign tests_failed_o = data_wr && data_region == REG_CNTRL && data_wdata_i != PASS_CODE;

    // other offsets in the timer region are ignored
    assign timer_ofs       = data_addr_i - TIMER_BASE;
    assign timer_sel_cnt_o = timer_ofs == TIMER_CNT_OFS;
    assign timer_we_o      = data_wr && data_region == REG_TIMER
                             && (timer_ofs == TIMER_MASK_OFS || timer_sel_cnt_o);
    assign timer_wdata_o   = data_wdata_i;

    assign data_sel_d  = data_rd ? sel_for(data_region) : SEL_IDLE;
    assign instr_sel_d = instr_gnt_o ? sel_for(instr_region) : SEL_IDLE;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_sel_q     <= SEL_IDLE;
            instr_sel_q    <= SEL_IDLE;
            data_rvalid_q  <= 1'b0;
            instr_rvalid_q <= 1'b0;
        end else begin
            data_sel_q     <= data_sel_d;
            instr_sel_q    <= instr_sel_d;
            data_rvalid_q  <= data_gnt_o;
            instr_rvalid_q <= instr_gnt_o;
        end
    end

    assign data_rvalid_o  = data_rvalid_q;
    assign instr_rvalid_o = instr_rvalid_q;
    assign data_rdata_o   = read_mux(data_sel_q, ram_port.rdata);
    assign instr_rdata_o  = read_mux(instr_sel_q, fetch_rdata_i);

endmodule

`default_nettype wire

// ==== design/mm_timer.sv ====
/*
 * Countdown timer. A mask register enables the interrupt, the count
 * register counts down once per cycle and raises irq when it expires.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_timer (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic              timer_we_i,
    input  wire logic              timer_sel_cnt_i,
    input  wire mm_bus_pkg::word_t timer_wdata_i,

    input  wire logic              irq_ack_i,
    input  wire logic [4:0]        irq_id_i,
    output logic                   irq_o
);
    import mm_bus_pkg::*;
    import mm_map_pkg::*;

    word_t mask_q;
    word_t cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_o  <= 1'b0;
        end else if (timer_we_i) begin
            // a write holds the count for this cycle
            if (timer_sel_cnt_i) begin
                cnt_q <= timer_wdata_i;
            end else begin
                mask_q <= timer_wdata_i;
            end
        end else begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - word_t'(1);
            end

            // expiry when leaving one
            if (cnt_q == word_t'(1) && mask_q[TIMER_IRQ_ID]) begin
                irq_o <= 1'b1;
            end

            // ack wins over a simultaneous expiry
            if (irq_ack_i && irq_id_i == TIMER_IRQ_ID) begin
                irq_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem/mm_ram.sv ====
/*
 * Dual-port word RAM. The data port reads and writes with byte enables,
 * the fetch port is read only. Both ports read synchronously.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_ram #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  wire logic                      clk_i,

    input  wire logic                      fetch_req_i,
    input  wire logic [RAM_ADDR_WIDTH-1:0] fetch_addr_i,
    output mm_bus_pkg::word_t              fetch_rdata_o,

    mem_port_if.mem                        data_port
);
    import mm_bus_pkg::*;

    localparam int unsigned WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    word_t                     mem [WORDS];
    logic [RAM_ADDR_WIDTH-3:0] data_idx;
    logic [RAM_ADDR_WIDTH-3:0] fetch_idx;

    // word index from the byte address
    assign data_idx  = data_port.addr[RAM_ADDR_WIDTH-1:2];
    assign fetch_idx = fetch_addr_i[RAM_ADDR_WIDTH-1:2];

    always_ff @(posedge clk_i) begin
        if (data_port.req) begin
            if (data_port.we) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (data_port.be[b]) begin
                        mem[data_idx][8*b +: 8] <= data_port.wdata[8*b +: 8];
                    end
                end
            end else begin
                data_port.rdata <= mem[data_idx];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_req_i) begin
            fetch_rdata_o <= mem[fetch_idx];
        end
    end

endmodule

`default_nettype wire

// ==== design/mm_ram_top.sv ====
/*
 * Simulation memory system top level. Connects the address decoder, the
 * dual-port RAM and the countdown timer to the core fetch and data ports.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_ram_top #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic              instr_req_i,
    input  wire mm_bus_pkg::addr_t instr_addr_i,
    output logic                   instr_gnt_o,
    output logic                   instr_rvalid_o,
    output mm_bus_pkg::word_t      instr_rdata_o,

    input  wire logic              data_req_i,
    input  wire mm_bus_pkg::addr_t data_addr_i,
    input  wire logic              data_we_i,
    input  wire mm_bus_pkg::be_t   data_be_i,
    input  wire mm_bus_pkg::word_t data_wdata_i,
    output logic                   data_gnt_o,
    output logic                   data_rvalid_o,
    output mm_bus_pkg::word_t      data_rdata_o,

    input  wire logic              irq_ack_i,
    input  wire logic [4:0]        irq_id_i,
    output logic                   irq_o,

    output logic                   tests_passed_o,
    output logic                   tests_failed_o
);
    import mm_bus_pkg::*;

    logic                      fetch_req;
    logic [RAM_ADDR_WIDTH-1:0] fetch_addr;
    word_t                     fetch_rdata;

    logic                      timer_we;
    logic                      timer_sel_cnt;
    word_t                     timer_wdata;

    mem_port_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) ram_port ();

    mm_decoder #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) u_decoder (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .ram_port       (ram_port.ctrl),
        .fetch_req_o    (fetch_req),
        .fetch_addr_o   (fetch_addr),
        .fetch_rdata_i  (fetch_rdata),
        .timer_we_o     (timer_we),
        .timer_sel_cnt_o(timer_sel_cnt),
        .timer_wdata_o  (timer_wdata)
    );

    mm_ram #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) u_ram (
        .clk_i        (clk_i),
        .fetch_req_i  (fetch_req),
        .fetch_addr_i (fetch_addr),
        .fetch_rdata_o(fetch_rdata),
        .data_port    (ram_port.mem)
    );

    mm_timer u_timer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .timer_we_i     (timer_we),
        .timer_sel_cnt_i(timer_sel_cnt),
        .timer_wdata_i  (timer_wdata),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_mm_ram.sv ====
/*
 * Testbench for the simulation memory system. Issues random RAM traffic,
 * fetches, boot ROM, unmapped, test control and timer accesses and checks
 * every response against a reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mm_ram;
    import mm_map_pkg::*;

    localparam int unsigned RAM_AW     = 16;
    localparam int unsigned CLK_PERIOD = 20;
    localparam int unsigned N_FILL     = 24;
    localparam int unsigned N_PART     = 40;
    localparam int unsigned N_READ     = 40;
    localparam int unsigned N_FETCH    = 24;
    localparam int unsigned N_SIDE     = 8;
    localparam int unsigned N_TIMER    = 4;
    localparam int unsigned MAX_CNT    = 50;
    // upper bound of the transactions issued by all tests
    localparam int unsigned N_TXN = N_FILL + N_PART + N_READ + 2 * N_FETCH
                                    + 9 * N_SIDE + 4 * N_TIMER;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        instr_req_i;
    logic [31:0] instr_addr_i;
    logic        instr_gnt_o;
    logic        instr_rvalid_o;
    logic [31:0] instr_rdata_o;
    logic        data_req_i;
    logic [31:0] data_addr_i;
    logic        data_we_i;
    logic [3:0]  data_be_i;
    logic [31:0] data_wdata_i;
    logic        data_gnt_o;
    logic        data_rvalid_o;
    logic [31:0] data_rdata_o;
    logic        irq_ack_i;
    logic [4:0]  irq_id_i;
    logic        irq_o;
    logic        tests_passed_o;
    logic        tests_failed_o;

    // reference model of the RAM indexed by word
    logic [31:0] model_mem [int unsigned];
    int unsigned used_idx [$];
    logic [31:0] data_exp_q [$];
    bit          data_chk_q [$];
    logic [31:0] instr_exp_q [$];
    logic        data_gnt_prev;
    logic        instr_gnt_prev;
    logic        exp_pass;
    logic        exp_fail;
    int unsigned n_checks;
    int unsigned n_errors;

    mm_ram_top #(
        .RAM_ADDR_WIDTH(RAM_AW)
    ) DUT (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .instr_req_i   (instr_req_i),
        .instr_addr_i  (instr_addr_i),
        .instr_gnt_o   (instr_gnt_o),
        .instr_rvalid_o(instr_rvalid_o),
        .instr_rdata_o (instr_rdata_o),
        .data_req_i    (data_req_i),
        .data_addr_i   (data_addr_i),
        .data_we_i     (data_we_i),
        .data_be_i     (data_be_i),
        .data_wdata_i  (data_wdata_i),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .irq_ack_i     (irq_ack_i),
        .irq_id_i      (irq_id_i),
        .irq_o         (irq_o),
        .tests_passed_o(tests_passed_o),
        .tests_failed_o(tests_failed_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    // picks the zero based or the SRAM_BASE alias at random
    function automatic logic [31:0] ram_addr(input int unsigned idx);
        logic [31:0] base;
        base = ($urandom_range(1, 0) == 1) ? SRAM_BASE : 32'h0;
        return base | (idx << 2);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0] be);
        logic [31:0] res;
        int          b;
        res = old;
        for (b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic int unsigned pick_used();
        return used_idx[$urandom_range(used_idx.size() - 1, 0)];
    endfunction

    // one data access that is granted in the cycle it is driven
    task automatic data_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                               input logic [31:0] wdata, input logic [31:0] exp,
                               input bit chk);
        data_req_i   = 1'b1;
        data_addr_i  = addr;
        data_we_i    = we;
        data_be_i    = be;
        data_wdata_i = wdata;
        @(negedge clk_i);
        check_value(data_gnt_o, 1'b1, "data grant");
        check_value(tests_passed_o, exp_pass, "tests_passed_o pulse");
        check_value(tests_failed_o, exp_fail, "tests_failed_o pulse");
        data_exp_q.push_back(exp);
        data_chk_q.push_back(chk);
        next_cycle();
        data_req_i = 1'b0;
    endtask

    task automatic fetch(input logic [31:0] addr, input logic [31:0] exp);
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        @(negedge clk_i);
        check_value(instr_gnt_o, 1'b1, "fetch grant");
        instr_exp_q.push_back(exp);
        next_cycle();
        instr_req_i = 1'b0;
    endtask

    task automatic fetch_beside_read(input int unsigned iidx, input int unsigned didx);
        instr_req_i  = 1'b1;
        instr_addr_i = ram_addr(iidx);
        data_req_i   = 1'b1;
        data_addr_i  = ram_addr(didx);
        data_we_i    = 1'b0;
        data_be_i    = 4'hF;
        @(negedge clk_i);
        check_value(instr_gnt_o, 1'b1, "ram fetch grant beside data read");
        check_value(data_gnt_o, 1'b1, "data grant beside ram fetch");
        instr_exp_q.push_back(model_mem[iidx]);
        data_exp_q.push_back(model_mem[didx]);
        data_chk_q.push_back(1'b1);
        next_cycle();
        instr_req_i = 1'b0;
        data_req_i  = 1'b0;
    endtask

    // a rom fetch waits while the data port is busy
    task automatic rom_fetch_stall(input int unsigned didx);
        instr_req_i  = 1'b1;
        instr_addr_i = ROM_BASE + 4 * $urandom_range(ROM_LEN / 4 - 1, 0);
        data_req_i   = 1'b1;
        data_addr_i  = ram_addr(didx);
        data_we_i    = 1'b0;
        data_be_i    = 4'hF;
        @(negedge clk_i);
        check_value(instr_gnt_o, 1'b0, "rom fetch held during data request");
        data_exp_q.push_back(model_mem[didx]);
        data_chk_q.push_back(1'b1);
        next_cycle();
        data_req_i = 1'b0;
        @(negedge clk_i);
        check_value(instr_gnt_o, 1'b1, "rom fetch granted on idle data port");
        instr_exp_q.push_back(BOOT_LOOP_INSTR);
        next_cycle();
        instr_req_i = 1'b0;
    endtask

    task automatic ram_tests();
        int unsigned idx;
        int unsigned i;
        logic [31:0] wdata;
        logic [3:0]  be;
        // full words first so that every used word is defined
        while (used_idx.size() < N_FILL) begin
            // the first words lie inside the rom offsets to catch leaking rom writes
            if (used_idx.size() < N_SIDE) begin
                idx = $urandom_range(ROM_LEN / 4 - 1, 0);
            end else begin
                idx = $urandom_range(2 ** (RAM_AW - 2) - 1, 0);
            end
            if (!model_mem.exists(idx)) begin
                wdata          = $urandom();
                model_mem[idx] = wdata;
                used_idx.push_back(idx);
                data_access(ram_addr(idx), 1'b1, 4'hF, wdata, 32'h0, 1'b0);
            end
        end
        for (i = 0; i < N_PART; i++) begin
            idx            = pick_used();
            wdata          = $urandom();
            be             = $urandom_range(15, 0);
            model_mem[idx] = merge_bytes(model_mem[idx], wdata, be);
            data_access(ram_addr(idx), 1'b1, be, wdata, 32'h0, 1'b0);
        end
        for (i = 0; i < N_READ; i++) begin
            idx = pick_used();
            data_access(ram_addr(idx), 1'b0, 4'hF, 32'h0, model_mem[idx], 1'b1);
        end
    endtask

    task automatic fetch_tests();
        int unsigned i;
        int unsigned idx;
        for (i = 0; i < N_FETCH; i++) begin
            idx = pick_used();
            if (i % 3 == 0) begin
                fetch(ram_addr(idx), model_mem[idx]);
            end else begin
                fetch_beside_read(idx, pick_used());
            end
        end
    endtask

    task automatic side_tests();
        int unsigned i;
        int unsigned idx;
        logic [31:0] rom_addr;
        logic [31:0] unmap_addr;
        logic [31:0] wdata;
        for (i = 0; i < N_SIDE; i++) begin
            idx        = used_idx[i];
            rom_addr   = ROM_BASE | (idx << 2);
            // low bits match a live RAM word, so a write leaking into RAM shows up
            unmap_addr = 32'h2000_0000 | (idx << 2);
            data_access(rom_addr, 1'b0, 4'hF, 32'h0, BOOT_LOOP_INSTR, 1'b1);
            fetch(rom_addr, BOOT_LOOP_INSTR);
            rom_fetch_stall(pick_used());
            data_access(unmap_addr, 1'b1, 4'hF, $urandom(), 32'h0, 1'b0);
            data_access(rom_addr, 1'b1, 4'hF, $urandom(), 32'h0, 1'b0);
            data_access(unmap_addr, 1'b0, 4'hF, 32'h0, 32'h0, 1'b1);
            data_access(ram_addr(idx), 1'b0, 4'hF, 32'h0, model_mem[idx], 1'b1);
            wdata = $urandom();
            if (i % 2 == 0) begin
                wdata    = PASS_CODE;
                exp_pass = 1'b1;
            end else begin
                if (wdata == PASS_CODE) begin
                    wdata = ~wdata;
                end
                exp_fail = 1'b1;
            end
            data_access(CNTRL_BASE + 4 * $urandom_range(CNTRL_LEN / 4 - 1, 0), 1'b1, 4'hF,
                        wdata, 32'h0, 1'b0);
            exp_pass = 1'b0;
            exp_fail = 1'b0;
        end
    endtask

    task automatic timer_tests();
        int unsigned i;
        int unsigned j;
        int unsigned n;
        logic        masked;
        for (i = 0; i < N_TIMER; i++) begin
            n      = $urandom_range(MAX_CNT, 2);
            masked = (i % 2 == 0);
            data_access(TIMER_BASE + TIMER_MASK_OFS, 1'b1, 4'hF,
                        masked ? (32'h1 << TIMER_IRQ_ID) : 32'h0, 32'h0, 1'b0);
            data_access(TIMER_BASE + TIMER_CNT_OFS, 1'b1, 4'hF, n, 32'h0, 1'b0);
            // the count write was taken at the last edge
            for (j = 1; j <= n + 2; j++) begin
                next_cycle();
                check_value(irq_o, masked && j >= n, "irq after count expiry");
            end
            if (masked) begin
                irq_ack_i = 1'b1;
                irq_id_i  = 5'(TIMER_IRQ_ID + $urandom_range(31, 1));
                next_cycle();
                check_value(irq_o, 1'b1, "irq kept on ack with other id");
                irq_id_i = TIMER_IRQ_ID;
                next_cycle();
                irq_ack_i = 1'b0;
                check_value(irq_o, 1'b0, "irq cleared by matching ack");
            end
        end
    endtask

    // response monitor checking that rvalid follows each grant by one cycle
    always @(negedge clk_i) begin
        if (rst_ni) begin
            check_value(data_rvalid_o, data_gnt_prev, "data rvalid after grant");
            check_value(instr_rvalid_o, instr_gnt_prev, "instr rvalid after grant");
            if (data_rvalid_o === 1'b1) begin
                if (data_exp_q.size() == 0) begin
                    n_errors++;
                    $display("ERROR at %0t: data rvalid with no pending request", $time);
                end else if (data_chk_q.pop_front()) begin
                    check_value(data_rdata_o, data_exp_q.pop_front(), "data read data");
                end else begin
                    void'(data_exp_q.pop_front());
                end
            end
            if (instr_rvalid_o === 1'b1) begin
                if (instr_exp_q.size() == 0) begin
                    n_errors++;
                    $display("ERROR at %0t: instr rvalid with no pending fetch", $time);
                end else begin
                    check_value(instr_rdata_o, instr_exp_q.pop_front(), "fetch read data");
                end
            end
            data_gnt_prev  = data_gnt_o;
            instr_gnt_prev = instr_gnt_o;
        end
    end

    // watchdog allowing one full count per timer round
    initial begin
        #(CLK_PERIOD * (N_TXN * 40 + N_TIMER * MAX_CNT));
        $display("ERROR: timeout, the test sequence did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(80));
        rst_ni         = 1'b0;
        instr_req_i    = 1'b0;
        instr_addr_i   = 32'h0;
        data_req_i     = 1'b0;
        data_addr_i    = 32'h0;
        data_we_i      = 1'b0;
        data_be_i      = 4'h0;
        data_wdata_i   = 32'h0;
        irq_ack_i      = 1'b0;
        irq_id_i       = 5'd0;
        data_gnt_prev  = 1'b0;
        instr_gnt_prev = 1'b0;
        exp_pass       = 1'b0;
        exp_fail       = 1'b0;
        n_checks       = 0;
        n_errors       = 0;
        repeat (3) @(posedge clk_i);
        check_value(data_rvalid_o, 1'b0, "data rvalid in reset");
        check_value(instr_rvalid_o, 1'b0, "instr rvalid in reset");
        check_value(irq_o, 1'b0, "irq in reset");
        #2;
        rst_ni = 1'b1;
        next_cycle();
        ram_tests();
        fetch_tests();
        side_tests();
        timer_tests();
        repeat (3) next_cycle();
        if (data_exp_q.size() != 0 || instr_exp_q.size() != 0) begin
            n_errors++;
            $display("ERROR: %0d data and %0d fetch responses never arrived",
                     data_exp_q.size(), instr_exp_q.size());
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mm_ram_top.f ====
common/mm_bus_pkg.sv
common/mm_map_pkg.sv
common/mem_port_if.sv
design/mm_decoder.sv
design/mm_timer.sv
mem/mm_ram.sv
design/mm_ram_top.sv
tb/tb_mm_ram.sv

// ==== Bender.yml ====
package:
  name: mm_ram_top

sources:
  # shared packages and the RAM port interface
  - common/mm_bus_pkg.sv
  - common/mm_map_pkg.sv
  - common/mem_port_if.sv
  # RTL
  - design/mm_decoder.sv
  - design/mm_timer.sv
  - mem/mm_ram.sv
  - design/mm_ram_top.sv
  # testbench
  - target: test
    files:
      - tb/tb_mm_ram.sv
